/* files.f */
src/eeprom_pkg.sv
src/serial_pkg.sv
src/scl_gen.sv
src/byte_shifter.sv
src/eeprom_ctrl.sv
src/eeprom_top.sv
verif/serial_mem_model.sv
verif/tb_eeprom.sv

/* run.sh */
#!/bin/sh
# build and run the eeprom testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_eeprom -f files.f -o tb_eeprom
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_eeprom 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* src/byte_shifter.sv */
`timescale 1ns/10ps

module byte_shifter (
    input  logic CLK,
    input  logic RESET,
    input  logic cmd_valid,
    input  serial_pkg::bit_cmd_t cmd,
    output logic cmd_ready,
    output logic done,
    output serial_pkg::bit_res_t res,
    input  logic low_mid,
    input  logic high_mid,
    output logic scl_run,
    output logic sda_pull,
    input  logic sda_in
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_START,
        S_BITS,
        S_ACK,
        S_STOP
    } state_e;

    state_e state;
    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic step;      // first half of the current slot is done
    logic rd_op;
    logic last_q;

    assign cmd_ready = (state == S_IDLE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= S_IDLE;
            scl_run <= 1'b0;
            sda_pull <= 1'b0;
            done <= 1'b0;
            step <= 1'b0;
            bit_cnt <= '0;
            rd_op <= 1'b0;
            last_q <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        step <= 1'b0;
                        bit_cnt <= '0;
                        rd_op <= (cmd.cmd == serial_pkg::CMD_READ);
                        last_q <= cmd.last;
                        case (cmd.cmd)
                            serial_pkg::CMD_START:
                            begin
                                state <= S_START;
                                if (!scl_run)
                                begin
                                    scl_run <= 1'b1;
                                    step <= 1'b1;   // bus free, sda already released
                                end
                            end
                            serial_pkg::CMD_STOP: state <= S_STOP;
                            default: state <= S_BITS;
                        endcase
                    end
                end
                S_START:
                begin
                    if (low_mid && !step)
                    begin
                        sda_pull <= 1'b0;   // release before repeated start
                        step <= 1'b1;
                    end
                    else if (high_mid && step)
                    begin
                        sda_pull <= 1'b1;   // sda falls with scl high
                        done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                S_BITS:
                begin
                    if (low_mid)
                    begin
                        sda_pull <= rd_op ? 1'b0 : ~shreg[7];
                        step <= 1'b1;
                    end
                    else if (high_mid && step)
                    begin
                        step <= 1'b0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= S_ACK;
                    end
                end
                S_ACK:
                begin
                    if (low_mid)
                    begin
                        sda_pull <= rd_op && !last_q;   // write releases for the slave ack
                        step <= 1'b1;
                    end
                    else if (high_mid && step)
                    begin
                        done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                S_STOP:
                begin
                    if (low_mid)
                    begin
                        sda_pull <= 1'b1;
                        step <= 1'b1;
                    end
                    else if (high_mid && step)
                    begin
                        sda_pull <= 1'b0;   // sda rises with scl high
                        scl_run <= 1'b0;
                        done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // data path, sampled bits shift in at the lsb
    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && cmd_valid)
            shreg <= cmd.wbyte;
        else if (state == S_BITS && high_mid && step)
            shreg <= {shreg[6:0], sda_in};
        if (state == S_ACK && high_mid && step)
        begin
            res.rbyte <= shreg;
            res.ack_missing <= !rd_op && sda_in;
        end
    end

    a_sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        high_mid && !(state inside {S_START, S_STOP}) |=> $stable(sda_pull));

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done);

endmodule

/* src/eeprom_ctrl.sv */
`timescale 1ns/10ps

module eeprom_ctrl (
    input  logic CLK,
    input  logic RESET,
    input  logic req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic req_ready,
    output logic rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    input  logic rsp_ready,
    output logic cmd_valid,
    output serial_pkg::bit_cmd_t cmd,
    input  logic cmd_ready,
    input  logic done,
    input  serial_pkg::bit_res_t res
);

    typedef enum logic [3:0]
    {
        M_IDLE,
        M_START,
        M_CTRL_W,
        M_ADDR,
        M_DATA_W,
        M_RESTART,
        M_CTRL_R,
        M_DATA_R,
        M_STOP,
        M_RESP
    } state_e;

    state_e state;
    state_e nxt;
    eeprom_pkg::eeprom_req_t req_q;
    logic pend;      // command for this state not yet taken
    logic nack_q;
    logic [7:0] rdata_q;
    logic miss;

    assign req_ready = (state == M_IDLE);
    assign rsp_valid = (state == M_RESP);
    assign cmd_valid = pend;
    assign rsp.rdata = rdata_q;
    assign rsp.nack = nack_q;
    assign miss = res.ack_missing;

    // where to go once the engine reports done
    always_comb
    begin
        case (state)
            M_START: nxt = M_CTRL_W;
            M_CTRL_W: nxt = miss ? M_STOP : M_ADDR;
            M_ADDR:
            begin
                if (miss)
                    nxt = M_STOP;
                else if (req_q.op == eeprom_pkg::OP_READ)
                    nxt = M_RESTART;
                else
                    nxt = M_DATA_W;
            end
            M_RESTART: nxt = M_CTRL_R;
            M_CTRL_R: nxt = miss ? M_STOP : M_DATA_R;
            M_STOP: nxt = M_RESP;
            default: nxt = M_STOP;   // both data bytes end in stop
        endcase
    end

    always_comb
    begin
        cmd.cmd = serial_pkg::CMD_WRITE;
        cmd.wbyte = 8'h00;
        cmd.last = 1'b0;
        case (state)
            M_START, M_RESTART: cmd.cmd = serial_pkg::CMD_START;
            M_CTRL_W: cmd.wbyte = {eeprom_pkg::DEV_CODE, req_q.addr[10:8], 1'b0};
            M_ADDR: cmd.wbyte = req_q.addr[7:0];
            M_DATA_W: cmd.wbyte = req_q.wdata;
            M_CTRL_R: cmd.wbyte = {eeprom_pkg::DEV_CODE, req_q.addr[10:8], 1'b1};
            M_DATA_R:
            begin
                cmd.cmd = serial_pkg::CMD_READ;
                cmd.last = 1'b1;   // single byte, master NACKs
            end
            default: cmd.cmd = serial_pkg::CMD_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= M_IDLE;
            pend <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (req_valid)
                    begin
                        state <= M_START;
                        pend <= 1'b1;
                        nack_q <= 1'b0;
                    end
                end
                M_RESP:
                begin
                    if (rsp_ready)
                        state <= M_IDLE;
                end
                default:
                begin
                    if (cmd_valid && cmd_ready)
                        pend <= 1'b0;
                    if (done)
                    begin
                        if (cmd.cmd == serial_pkg::CMD_WRITE)
                            nack_q <= nack_q | miss;   // sticky over write bytes
                        state <= nxt;
                        pend <= (nxt != M_RESP);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
            req_q <= req;
        if (done && state == M_DATA_R)
            rdata_q <= res.rbyte;
    end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

    a_idle_no_cmd: assert property (@(posedge CLK) disable iff (RESET)
        state == M_IDLE |-> !cmd_valid);

endmodule

/* src/eeprom_pkg.sv */
package eeprom_pkg;

    // upper nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // host request, one byte per transaction
    typedef struct packed
    {
        eeprom_op_e op;
        logic [10:0] addr;   // bits 10..8 ride in the control byte
        logic [7:0] wdata;
    } eeprom_req_t;

    typedef struct packed
    {
        logic [7:0] rdata;   // valid for reads with nack clear
        logic nack;          // some slave ack was missing
    } eeprom_rsp_t;

endpackage

/* src/eeprom_top.sv */
`timescale 1ns/10ps

module eeprom_top #(
    parameter int SCL_HALF = 4
) (
    input  logic CLK,
    input  logic RESET,
    input  logic req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic req_ready,
    output logic rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    input  logic rsp_ready,
    output logic scl,
    output logic sda_pull,
    input  logic sda_in
);

    logic cmd_valid;
    logic cmd_ready;
    serial_pkg::bit_cmd_t cmd;
    logic done;
    serial_pkg::bit_res_t res;
    logic scl_run;
    logic low_mid;
    logic high_mid;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .done      (done),
        .res       (res)
    );

    byte_shifter u_shifter (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .done      (done),
        .res       (res),
        .low_mid   (low_mid),
        .high_mid  (high_mid),
        .scl_run   (scl_run),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

    scl_gen #(
        .SCL_HALF (SCL_HALF)
    ) u_scl (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl_run  (scl_run),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

endmodule

/* src/scl_gen.sv */
`timescale 1ns/10ps

module scl_gen #(
    parameter int SCL_HALF = 4
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl_run,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    localparam int CW = $clog2(SCL_HALF + 1);
    localparam logic [CW-1:0] LAST = CW'(SCL_HALF - 1);
    localparam logic [CW-1:0] MID = CW'(SCL_HALF / 2);

    logic [CW-1:0] cnt;
    logic at_mid;

    always_ff @(posedge CLK)
    begin
        if (RESET || !scl_run)
        begin
            cnt <= '0;
            scl <= 1'b1;   // parked high when idle
        end
        else if (cnt == LAST)
        begin
            cnt <= '0;
            scl <= ~scl;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    assign at_mid = scl_run && (cnt == MID);
    assign low_mid = at_mid && !scl;
    assign high_mid = at_mid && scl;

endmodule

/* src/serial_pkg.sv */
package serial_pkg;

    // CMD_START doubles as repeated start
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2,
        CMD_STOP  = 2'd3
    } bit_cmd_e;

    typedef struct packed
    {
        bit_cmd_e cmd;
        logic [7:0] wbyte;
        logic last;          // read only, master NACKs the byte
    } bit_cmd_t;

    typedef struct packed
    {
        logic [7:0] rbyte;
        logic ack_missing;   // write only
    } bit_res_t;

endpackage

/* verif/serial_mem_model.sv */
`timescale 1ns/10ps

module serial_mem_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic pull,
    output logic bus_err
);

    logic [7:0] mem [0:1023];
    logic scl_q;
    logic sda_q;
    logic active;
    logic sending;
    logic have_bit;        // a bit was sampled on the last rising edge
    logic bit_val;
    logic [3:0] bit_cnt;   // 8 is the ack slot
    logic [1:0] byte_idx;
    logic rw_q;
    logic [7:0] shreg;
    logic [7:0] tx;
    logic [9:0] ptr;
    logic [7:0] rx;

    initial
    begin
        // address bit 10 is always zero here
        for (int a = 0; a < 1024; a++)
            mem[a] = a[7:0] ^ {1'b0, a[9:8], 5'd0} ^ 8'h5a;
    end

    assign rx = {shreg[6:0], bit_val};

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            active <= 1'b0;
            sending <= 1'b0;
            have_bit <= 1'b0;
            bit_cnt <= '0;
            byte_idx <= '0;
            pull <= 1'b0;
            bus_err <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda != sda_q)
            begin
                if (active && bit_cnt != 4'd0)
                begin
                    $display("memory model: SDA changed while SCL was high inside a byte");
                    bus_err <= 1'b1;
                end
                else if (!sda)
                begin
                    active <= 1'b1;   // start or repeated start
                    byte_idx <= '0;
                end
                else
                    active <= 1'b0;   // stop
                sending <= 1'b0;
                have_bit <= 1'b0;
                bit_cnt <= '0;
                pull <= 1'b0;
            end
            else if (scl && !scl_q)
            begin
                have_bit <= 1'b1;
                bit_val <= sda;
            end
            else if (!scl && scl_q && active && have_bit)
            begin
                have_bit <= 1'b0;
                if (bit_cnt < 4'd7)
                begin
                    shreg <= rx;
                    bit_cnt <= bit_cnt + 4'd1;
                    if (sending)
                    begin
                        pull <= ~tx[6];
                        tx <= tx << 1;
                    end
                end
                else if (bit_cnt == 4'd7)
                begin
                    bit_cnt <= 4'd8;
                    pull <= 1'b0;
                    if (!sending)
                    begin
                        case (byte_idx)
                            2'd0:
                            begin
                                if (rx[7:4] == 4'b1010 && !rx[3])
                                begin
                                    pull <= 1'b1;
                                    rw_q <= rx[0];
                                    byte_idx <= 2'd1;
                                    if (!rx[0])
                                        ptr[9:8] <= rx[2:1];
                                end
                                else
                                begin
                                    active <= 1'b0;   // no device, ignore until next start
                                    bit_cnt <= '0;
                                end
                            end
                            2'd1:
                            begin
                                ptr[7:0] <= rx;
                                pull <= 1'b1;
                                byte_idx <= 2'd2;
                            end
                            2'd2:
                            begin
                                mem[ptr] <= rx;
                                pull <= 1'b1;
                                byte_idx <= 2'd3;
                            end
                            default: pull <= 1'b0;   // no page writes
                        endcase
                    end
                end
                else
                begin
                    bit_cnt <= '0;
                    pull <= 1'b0;
                    sending <= 1'b0;
                    if (!sending && rw_q && byte_idx == 2'd1)
                    begin
                        sending <= 1'b1;
                        tx <= mem[ptr];
                        pull <= ~mem[ptr][7];
                        byte_idx <= 2'd3;
                    end
                end
            end
        end
    end

endmodule

/* verif/tb_eeprom.sv */
`timescale 1ns/10ps

module tb_eeprom #(
    parameter int SCL_HALF = 4
);

    localparam int NUM_TXN = 222;
    localparam int LIMIT = NUM_TXN * 60 * 2 * SCL_HALF * 2;

    logic CLK;
    logic RESET;
    logic req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic req_ready;
    logic rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic rsp_ready;
    logic scl;
    logic sda_pull;
    logic mem_pull;
    logic sda;
    logic bus_err;
    logic [7:0] sb [0:2047];
    logic written [0:1023];
    int cycles;

    assign sda = !(sda_pull || mem_pull);   // wired-AND bus

    eeprom_top #(
        .SCL_HALF (SCL_HALF)
    ) DUT (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda)
    );

    serial_mem_model u_mem (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl     (scl),
        .sda     (sda),
        .pull    (mem_pull),
        .bus_err (bus_err)
    );

    always #20 CLK = ~CLK;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [7:0] fill_byte(input logic [10:0] addr);
        return addr[7:0] ^ {addr[10:8], 5'd0} ^ 8'h5a;
    endfunction

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout: no finish after %0d cycles", cycles);
            abort_run();
        end
    end

    always @(negedge CLK)
    begin
        if (bus_err)
        begin
            $display("memory model saw an illegal SDA change on the bus");
            abort_run();
        end
    end

    task automatic send_request(input eeprom_pkg::eeprom_op_e op, input logic [10:0] addr,
                                input logic [7:0] wdata, input int gap);
        repeat (gap) @(posedge CLK);
        @(posedge CLK);
        req_valid <= 1'b1;
        req.op <= op;
        req.addr <= addr;
        req.wdata <= wdata;
        do @(negedge CLK); while (!req_ready);
        @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    // stall holds rsp_ready low, the bus must stay parked meanwhile
    task automatic take_response(input int stall, output eeprom_pkg::eeprom_rsp_t got);
        do @(negedge CLK); while (!rsp_valid);
        got = rsp;
        for (int i = 0; i < stall; i++)
        begin
            @(negedge CLK);
            check_value("stall rsp_valid", 1, rsp_valid);
            check_value("stall rsp", got, rsp);
            check_value("stall req_ready", 0, req_ready);
            check_value("stall scl", 1, scl);
        end
        @(posedge CLK);
        rsp_ready <= 1'b1;
        @(posedge CLK);
        rsp_ready <= 1'b0;
    endtask

    task automatic run_txn(input string name, input eeprom_pkg::eeprom_op_e op,
                           input logic [10:0] addr, input logic [7:0] wdata,
                           input int stall, output eeprom_pkg::eeprom_rsp_t got);
        send_request(op, addr, wdata, $urandom % 4);
        take_response(stall, got);
        check_value({name, " nack"}, addr[10], got.nack);   // bit 10 selects no device
        if (!addr[10] && op == eeprom_pkg::OP_READ)
            check_value({name, " rdata"}, sb[addr], got.rdata);
        if (!addr[10] && op == eeprom_pkg::OP_WRITE)
        begin
            sb[addr] = wdata;
            written[addr[9:0]] = 1'b1;
        end
    endtask

    initial
    begin
        eeprom_pkg::eeprom_rsp_t got;
        eeprom_pkg::eeprom_op_e op;
        logic [10:0] addr;
        logic [7:0] data;
        int unsigned seed_val;

        CLK = 1'b0;
        RESET = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        cycles = 0;
        seed_val = $urandom(32'h106e);
        for (int i = 0; i < 2048; i++)
            sb[i] = fill_byte(11'(i));
        for (int i = 0; i < 1024; i++)
            written[i] = 1'b0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        @(negedge CLK);
        check_value("reset req_ready", 1, req_ready);
        check_value("reset rsp_valid", 0, rsp_valid);
        check_value("reset scl", 1, scl);
        check_value("reset sda_pull", 0, sda_pull);

        for (int n = 0; n < 4; n++)
        begin
            addr = 11'($urandom % 1024);
            data = 8'($urandom);
            run_txn("write", eeprom_pkg::OP_WRITE, addr, data, $urandom % 21, got);
            run_txn("readback", eeprom_pkg::OP_READ, addr, 8'h00, $urandom % 21, got);
            check_value("readback data", data, got.rdata);
        end

        for (int n = 0; n < 3; n++)
        begin
            do addr = 11'($urandom % 1024); while (written[addr[9:0]]);
            run_txn("unwritten", eeprom_pkg::OP_READ, addr, 8'h00, $urandom % 21, got);
            check_value("unwritten pattern", fill_byte(addr), got.rdata);
        end

        for (int n = 0; n < 3; n++)
        begin
            addr = 11'($urandom % 1024) | 11'h400;
            run_txn("absent write", eeprom_pkg::OP_WRITE, addr, 8'($urandom), 3, got);
            run_txn("absent read", eeprom_pkg::OP_READ, addr, 8'h00, 3, got);
            run_txn("absent alias", eeprom_pkg::OP_READ, addr & 11'h3ff, 8'h00, 3, got);
        end

        // longest stall on both kinds
        run_txn("stall write", eeprom_pkg::OP_WRITE, 11'($urandom % 1024), 8'($urandom), 20, got);
        run_txn("stall read", eeprom_pkg::OP_READ, 11'($urandom % 1024), 8'h00, 20, got);

        for (int n = 0; n < 200; n++)
        begin
            op = ($urandom % 2 != 0) ? eeprom_pkg::OP_READ : eeprom_pkg::OP_WRITE;
            addr = 11'($urandom % 1024);
            if ($urandom % 8 == 0)
                addr[10] = 1'b1;
            run_txn("random", op, addr, 8'($urandom), $urandom % 21, got);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule
